/* verilog.f */
+incdir+src
src/hd_reg_pkg.sv
src/hd_pipe_pkg.sv
src/int_scoreboard.sv
src/dep_status_pipe.sv
src/data_hazard_check.sv
src/issue_gate.sv
src/hazard_detector.sv
testbench/tb_hazard_detector.sv

/* Bender.yml */
package:
  name: hazard_detector

sources:
  - include_dirs:
      - src
    files:
      - src/hd_reg_pkg.sv
      - src/hd_pipe_pkg.sv
      - src/int_scoreboard.sv
      - src/dep_status_pipe.sv
      - src/data_hazard_check.sv
      - src/issue_gate.sv
      - src/hazard_detector.sv

  - target: test
    files:
      - testbench/tb_hazard_detector.sv

/* testbench/tb_hazard_detector.sv */
`timescale 1ns/1ps

module tb_hazard_detector;

  import hd_reg_pkg::*;
  import hd_pipe_pkg::*;

  logic      clk_i;
  logic      rst_i;
  reg_addr_t isd_rs1_i;
  reg_addr_t isd_rs2_i;
  reg_addr_t isd_rd_i;
  logic      isd_irs1_v_i;
  logic      isd_irs2_v_i;
  logic      isd_iwb_v_i;
  logic      isd_fence_i;
  logic      isd_mem_i;
  logic      isd_csr_i;
  logic      isd_long_i;
  logic      dispatch_v_i;
  reg_addr_t dispatch_rd_i;
  logic      dispatch_irf_w_i;
  lat_t      dispatch_lat_i;
  logic      dispatch_mem_i;
  logic      dispatch_late_i;
  logic      commit_miss_i;
  logic      commit_load_i;
  reg_addr_t commit_rd_i;
  logic      iwb_late_v_i;
  reg_addr_t iwb_rd_i;
  logic      cmd_full_i;
  logic      credits_full_i;
  logic      credits_empty_i;
  logic      idiv_ready_i;
  logic      mem_ready_i;
  logic      ptw_busy_i;
  logic      irq_pending_i;
  logic      dispatch_v_o;
  logic      interrupt_v_o;

  int errors;
  int checks;

  hazard_detector i_hazard_detector (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic expect_bit(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected)
      report_error($sformatf("%s: expected %0b, got %0b", what, expected, actual));
  endtask

  // Back to an idle instruction and idle units on the next edge
  task automatic idle_inputs();
    @(posedge clk_i);
    isd_irs1_v_i    <= 1'b0;
    isd_irs2_v_i    <= 1'b0;
    isd_iwb_v_i     <= 1'b0;
    isd_fence_i     <= 1'b0;
    isd_mem_i       <= 1'b0;
    isd_csr_i       <= 1'b0;
    isd_long_i      <= 1'b0;
    dispatch_v_i    <= 1'b0;
    dispatch_late_i <= 1'b0;
    commit_miss_i   <= 1'b0;
    commit_load_i   <= 1'b0;
    iwb_late_v_i    <= 1'b0;
    cmd_full_i      <= 1'b0;
    credits_full_i  <= 1'b0;
    credits_empty_i <= 1'b1;
    idiv_ready_i    <= 1'b1;
    mem_ready_i     <= 1'b1;
    ptw_busy_i      <= 1'b0;
    irq_pending_i   <= 1'b0;
  endtask

  // Empty records push out the three EX stages
  task automatic settle_pipe();
    idle_inputs();
    repeat (3) @(posedge clk_i);
  endtask

  // Returns just after the capture edge, dispatch already deasserted
  task automatic dispatch_one(input reg_addr_t rd, input lat_t lat, input logic mem,
                              input logic late);
    @(posedge clk_i);
    dispatch_v_i     <= 1'b1;
    dispatch_rd_i    <= rd;
    dispatch_irf_w_i <= 1'b1;
    dispatch_lat_i   <= lat;
    dispatch_mem_i   <= mem;
    dispatch_late_i  <= late;
    @(posedge clk_i);
    dispatch_v_i    <= 1'b0;
    dispatch_late_i <= 1'b0;
  endtask

  task automatic count_blocked(output int cycles);
    cycles = 0;
    @(negedge clk_i);
    while (dispatch_v_o !== 1'b1)
    begin
      cycles++;
      if (cycles >= 20)
      begin
        errors++;
        $display("Timeout at %0t ns: dispatch_v_o stayed low for 20 cycles", $time);
        break;
      end
      @(negedge clk_i);
    end
  endtask

  // Stall rules for an empty EX pipe and no data dependences
  function automatic logic expected_dispatch();
    logic stall;
    stall = ptw_busy_i | cmd_full_i;
    if (isd_fence_i && (!credits_empty_i || !mem_ready_i))
      stall = 1'b1;
    if (isd_mem_i && (credits_full_i || !mem_ready_i))
      stall = 1'b1;
    if (isd_long_i && !idiv_ready_i)
      stall = 1'b1;
    return !stall;
  endfunction

  task automatic test_idle();
    idle_inputs();
    isd_rs1_i    <= reg_addr_t'($urandom_range(0, 31));
    isd_rs2_i    <= reg_addr_t'($urandom_range(0, 31));
    isd_rd_i     <= reg_addr_t'($urandom_range(0, 31));
    isd_irs1_v_i <= 1'b1;
    isd_irs2_v_i <= 1'b1;
    isd_iwb_v_i  <= 1'b1;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "idle dispatch");
    for (int c = 0; c < 4; c++)
    begin
      @(posedge clk_i);
      irq_pending_i <= c[1];
      ptw_busy_i    <= c[0];
      @(negedge clk_i);
      expect_bit(interrupt_v_o, c[1] & ~c[0], $sformatf("interrupt irq=%0b ptw=%0b", c[1], c[0]));
    end
  endtask

  task automatic test_ex_raw();
    reg_addr_t r;
    settle_pipe();
    for (int lat = 0; lat < 3; lat++)
    begin
      r = reg_addr_t'($urandom_range(1, 31));
      dispatch_one(r, lat_t'(lat), 1'b0, 1'b0);
      isd_rs1_i    <= r;
      isd_irs1_v_i <= 1'b1;
      isd_rs2_i    <= '0;
      isd_irs2_v_i <= 1'b1;
      @(negedge clk_i);
      expect_bit(dispatch_v_o, lat < 1, $sformatf("RAW lat %0d cycle N+1", lat));
      @(negedge clk_i);
      expect_bit(dispatch_v_o, lat < 2, $sformatf("RAW lat %0d cycle N+2", lat));
      @(negedge clk_i);
      expect_bit(dispatch_v_o, 1'b1, $sformatf("RAW lat %0d cycle N+3", lat));
    end
    // A producer without an integer write leaves nothing to wait for
    r = reg_addr_t'($urandom_range(1, 31));
    @(posedge clk_i);
    dispatch_v_i     <= 1'b1;
    dispatch_rd_i    <= r;
    dispatch_irf_w_i <= 1'b0;
    dispatch_lat_i   <= lat_t'(2);
    dispatch_mem_i   <= 1'b0;
    @(posedge clk_i);
    dispatch_v_i <= 1'b0;
    isd_rs1_i    <= r;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "RAW on producer without integer write");
    // A producer writing x0 never blocks a reader of x0
    dispatch_one('0, lat_t'(2), 1'b0, 1'b0);
    isd_rs1_i <= '0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "read of x0");
  endtask

  task automatic test_scoreboard();
    reg_addr_t r;
    reg_addr_t r2;
    settle_pipe();
    r  = reg_addr_t'($urandom_range(1, 31));
    r2 = reg_addr_t'($urandom_range(1, 31));
    dispatch_one(r, lat_t'(0), 1'b0, 1'b1);
    isd_rs1_i    <= r;
    isd_irs1_v_i <= 1'b1;
    repeat (4)
    begin
      @(negedge clk_i);
      expect_bit(dispatch_v_o, 1'b0, "RAW on late destination");
    end
    @(posedge clk_i);
    isd_irs1_v_i <= 1'b0;
    isd_iwb_v_i  <= 1'b1;
    isd_rd_i     <= r;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b0, "WAW on late destination");
    @(posedge clk_i);
    iwb_late_v_i <= 1'b1;
    iwb_rd_i     <= r;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b0, "WAW in clear cycle");
    @(posedge clk_i);
    iwb_late_v_i <= 1'b0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "WAW after clear");
    // Load miss at commit scores its destination again
    @(posedge clk_i);
    isd_iwb_v_i   <= 1'b0;
    isd_rs2_i     <= r2;
    isd_irs2_v_i  <= 1'b1;
    commit_miss_i <= 1'b1;
    commit_load_i <= 1'b1;
    commit_rd_i   <= r2;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "RAW in commit miss cycle");
    @(posedge clk_i);
    commit_miss_i <= 1'b0;
    commit_load_i <= 1'b0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b0, "RAW after commit miss");
    @(posedge clk_i);
    iwb_late_v_i <= 1'b1;
    iwb_rd_i     <= r2;
    @(posedge clk_i);
    iwb_late_v_i <= 1'b0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "RAW after late writeback");
  endtask

  task automatic test_control();
    int cycles;
    settle_pipe();
    dispatch_one(reg_addr_t'($urandom_range(1, 31)), lat_t'(0), 1'b0, 1'b0);
    isd_csr_i <= 1'b1;
    count_blocked(cycles);
    checks++;
    if (cycles != 3)
      report_error($sformatf("CSR blocked %0d cycles, expected 3", cycles));
    dispatch_one(reg_addr_t'($urandom_range(1, 31)), lat_t'(0), 1'b0, 1'b0);
    isd_csr_i  <= 1'b0;
    isd_long_i <= 1'b1;
    count_blocked(cycles);
    checks++;
    if (cycles != 3)
      report_error($sformatf("long op blocked %0d cycles, expected 3", cycles));
    dispatch_one(reg_addr_t'($urandom_range(1, 31)), lat_t'(1), 1'b1, 1'b0);
    isd_long_i  <= 1'b0;
    isd_fence_i <= 1'b1;
    count_blocked(cycles);
    checks++;
    if (cycles != 3)
      report_error($sformatf("fence behind memory op blocked %0d cycles, expected 3", cycles));
    @(posedge clk_i);
    credits_empty_i <= 1'b0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b0, "fence with credits outstanding");
    @(posedge clk_i);
    credits_empty_i <= 1'b1;
    mem_ready_i     <= 1'b0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b0, "fence with memory not ready");
    @(posedge clk_i);
    mem_ready_i    <= 1'b1;
    isd_fence_i    <= 1'b0;
    isd_mem_i      <= 1'b1;
    credits_full_i <= 1'b1;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b0, "memory op with credits full");
    @(posedge clk_i);
    credits_full_i <= 1'b0;
    @(negedge clk_i);
    expect_bit(dispatch_v_o, 1'b1, "memory op with free credit");
  endtask

  task automatic test_structural_random();
    int cls;
    settle_pipe();
    repeat (200)
    begin
      @(posedge clk_i);
      cls = $urandom_range(0, 4);
      isd_fence_i     <= (cls == 1);
      isd_mem_i       <= (cls == 2);
      isd_csr_i       <= (cls == 3);
      isd_long_i      <= (cls == 4);
      cmd_full_i      <= ($urandom_range(0, 3) == 0);
      credits_full_i  <= ($urandom_range(0, 3) == 0);
      credits_empty_i <= ($urandom_range(0, 3) != 0);
      idiv_ready_i    <= ($urandom_range(0, 3) != 0);
      mem_ready_i     <= ($urandom_range(0, 3) != 0);
      ptw_busy_i      <= ($urandom_range(0, 3) == 0);
      irq_pending_i   <= ($urandom_range(0, 1) == 1);
      @(negedge clk_i);
      expect_bit(dispatch_v_o, expected_dispatch(), $sformatf("random class %0d", cls));
      expect_bit(interrupt_v_o, ptw_busy_i ? 1'b0 : irq_pending_i, "random interrupt");
    end
  endtask

  initial
  begin
    errors = 0;
    checks = 0;
    void'($urandom(54));
    rst_i            = 1'b1;
    isd_rs1_i        = '0;
    isd_rs2_i        = '0;
    isd_rd_i         = '0;
    isd_irs1_v_i     = 1'b0;
    isd_irs2_v_i     = 1'b0;
    isd_iwb_v_i      = 1'b0;
    isd_fence_i      = 1'b0;
    isd_mem_i        = 1'b0;
    isd_csr_i        = 1'b0;
    isd_long_i       = 1'b0;
    dispatch_v_i     = 1'b0;
    dispatch_rd_i    = '0;
    dispatch_irf_w_i = 1'b0;
    dispatch_lat_i   = '0;
    dispatch_mem_i   = 1'b0;
    dispatch_late_i  = 1'b0;
    commit_miss_i    = 1'b0;
    commit_load_i    = 1'b0;
    commit_rd_i      = '0;
    iwb_late_v_i     = 1'b0;
    iwb_rd_i         = '0;
    cmd_full_i       = 1'b0;
    credits_full_i   = 1'b0;
    credits_empty_i  = 1'b1;
    idiv_ready_i     = 1'b1;
    mem_ready_i      = 1'b1;
    ptw_busy_i       = 1'b0;
    irq_pending_i    = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    test_idle();
    test_ex_raw();
    test_scoreboard();
    test_control();
    test_structural_random();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* src/hazard_detector.sv */
`timescale 1ns/1ps
`include "hd_cfg.svh"

module hazard_detector (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Instruction waiting at issue
  input  hd_reg_pkg::reg_addr_t isd_rs1_i,
  input  hd_reg_pkg::reg_addr_t isd_rs2_i,
  input  hd_reg_pkg::reg_addr_t isd_rd_i,
  input  logic                  isd_irs1_v_i,
  input  logic                  isd_irs2_v_i,
  input  logic                  isd_iwb_v_i,
  input  logic                  isd_fence_i,
  input  logic                  isd_mem_i,
  input  logic                  isd_csr_i,
  input  logic                  isd_long_i,
  // Instruction dispatched this cycle
  input  logic                  dispatch_v_i,
  input  hd_reg_pkg::reg_addr_t dispatch_rd_i,
  input  logic                  dispatch_irf_w_i,
  input  hd_pipe_pkg::lat_t     dispatch_lat_i,
  input  logic                  dispatch_mem_i,
  input  logic                  dispatch_late_i,
  // Commit and late writeback
  input  logic                  commit_miss_i,
  input  logic                  commit_load_i,
  input  hd_reg_pkg::reg_addr_t commit_rd_i,
  input  logic                  iwb_late_v_i,
  input  hd_reg_pkg::reg_addr_t iwb_rd_i,
  // Unit status
  input  logic                  cmd_full_i,
  input  logic                  credits_full_i,
  input  logic                  credits_empty_i,
  input  logic                  idiv_ready_i,
  input  logic                  mem_ready_i,
  input  logic                  ptw_busy_i,
  input  logic                  irq_pending_i,
  output logic                  dispatch_v_o,
  output logic                  interrupt_v_o
);

  import hd_reg_pkg::*;
  import hd_pipe_pkg::*;

  stage_vec_t                     stage_v;
  stage_vec_t                     stage_mem;
  reg_addr_t [`HD_DEP_STAGES-1:0] stage_rd;
  lat_t [`HD_DEP_STAGES-1:0]      stage_lat;
  logic                           rs1_pend;
  logic                           rs2_pend;
  logic                           rd_pend;
  logic                           data_haz;

  int_scoreboard i_int_scoreboard (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .dispatch_v_i    (dispatch_v_i),
    .dispatch_late_i (dispatch_late_i),
    .dispatch_rd_i   (dispatch_rd_i),
    .commit_miss_i   (commit_miss_i),
    .commit_load_i   (commit_load_i),
    .commit_rd_i     (commit_rd_i),
    .clear_v_i       (iwb_late_v_i),
    .clear_rd_i      (iwb_rd_i),
    .rs1_i           (isd_rs1_i),
    .rs2_i           (isd_rs2_i),
    .rd_i            (isd_rd_i),
    .rs1_pend_o      (rs1_pend),
    .rs2_pend_o      (rs2_pend),
    .rd_pend_o       (rd_pend)
  );

  dep_status_pipe i_dep_status_pipe (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .dispatch_v_i     (dispatch_v_i),
    .dispatch_irf_w_i (dispatch_irf_w_i),
    .dispatch_rd_i    (dispatch_rd_i),
    .dispatch_lat_i   (dispatch_lat_i),
    .dispatch_mem_i   (dispatch_mem_i),
    .stage_v_o        (stage_v),
    .stage_mem_o      (stage_mem),
    .stage_rd_o       (stage_rd),
    .stage_lat_o      (stage_lat)
  );

  data_hazard_check i_data_hazard_check (
    .isd_rs1_i    (isd_rs1_i),
    .isd_rs2_i    (isd_rs2_i),
    .isd_rd_i     (isd_rd_i),
    .isd_irs1_v_i (isd_irs1_v_i),
    .isd_irs2_v_i (isd_irs2_v_i),
    .isd_iwb_v_i  (isd_iwb_v_i),
    .stage_v_i    (stage_v),
    .stage_rd_i   (stage_rd),
    .stage_lat_i  (stage_lat),
    .rs1_pend_i   (rs1_pend),
    .rs2_pend_i   (rs2_pend),
    .rd_pend_i    (rd_pend),
    .data_haz_o   (data_haz)
  );

  issue_gate i_issue_gate (
    .isd_fence_i     (isd_fence_i),
    .isd_mem_i       (isd_mem_i),
    .isd_csr_i       (isd_csr_i),
    .isd_long_i      (isd_long_i),
    .stage_v_i       (stage_v),
    .stage_mem_i     (stage_mem),
    .data_haz_i      (data_haz),
    .cmd_full_i      (cmd_full_i),
    .credits_full_i  (credits_full_i),
    .credits_empty_i (credits_empty_i),
    .idiv_ready_i    (idiv_ready_i),
    .mem_ready_i     (mem_ready_i),
    .ptw_busy_i      (ptw_busy_i),
    .irq_pending_i   (irq_pending_i),
    .dispatch_v_o    (dispatch_v_o),
    .interrupt_v_o   (interrupt_v_o)
  );

endmodule

/* src/issue_gate.sv */
`timescale 1ns/1ps

module issue_gate (
  input  logic                    isd_fence_i,
  input  logic                    isd_mem_i,
  input  logic                    isd_csr_i,
  input  logic                    isd_long_i,
  input  hd_pipe_pkg::stage_vec_t stage_v_i,
  input  hd_pipe_pkg::stage_vec_t stage_mem_i,
  input  logic                    data_haz_i,
  input  logic                    cmd_full_i,
  input  logic                    credits_full_i,
  input  logic                    credits_empty_i,
  input  logic                    idiv_ready_i,
  input  logic                    mem_ready_i,
  input  logic                    ptw_busy_i,
  input  logic                    irq_pending_i,
  output logic                    dispatch_v_o,
  output logic                    interrupt_v_o
);

  logic mem_in_pipe;
  logic pipe_busy;
  logic fence_haz;
  logic csr_haz;
  logic long_haz;
  logic struct_haz;

  assign mem_in_pipe = |(stage_v_i & stage_mem_i);
  assign pipe_busy   = |stage_v_i;

  // Fence drains memory traffic; memory ops need a free credit
  assign fence_haz = (isd_fence_i & (~credits_empty_i | mem_in_pipe | ~mem_ready_i))
                   | (isd_mem_i & credits_full_i);

  // CSR and long ops wait for an empty EX pipe
  assign csr_haz  = isd_csr_i & pipe_busy;
  assign long_haz = isd_long_i & pipe_busy;

  assign struct_haz = ptw_busy_i
                    | cmd_full_i
                    | (isd_mem_i & ~mem_ready_i)
                    | (isd_long_i & ~idiv_ready_i);

  assign dispatch_v_o = ~(data_haz_i | fence_haz | csr_haz | long_haz | struct_haz);

  // Page walk in progress holds off interrupts
  assign interrupt_v_o = irq_pending_i & ~ptw_busy_i;

endmodule

/* src/data_hazard_check.sv */
`timescale 1ns/1ps
`include "hd_cfg.svh"

module data_hazard_check (
  input  hd_reg_pkg::reg_addr_t                       isd_rs1_i,
  input  hd_reg_pkg::reg_addr_t                       isd_rs2_i,
  input  hd_reg_pkg::reg_addr_t                       isd_rd_i,
  input  logic                                        isd_irs1_v_i,
  input  logic                                        isd_irs2_v_i,
  input  logic                                        isd_iwb_v_i,
  input  hd_pipe_pkg::stage_vec_t                     stage_v_i,
  input  hd_reg_pkg::reg_addr_t [`HD_DEP_STAGES-1:0]  stage_rd_i,
  input  hd_pipe_pkg::lat_t [`HD_DEP_STAGES-1:0]      stage_lat_i,
  input  logic                                        rs1_pend_i,
  input  logic                                        rs2_pend_i,
  input  logic                                        rd_pend_i,
  output logic                                        data_haz_o
);

  import hd_reg_pkg::*;
  import hd_pipe_pkg::*;

  logic rs1_haz;
  logic rs2_haz;
  logic waw_haz;

  // RAW check for one source against the EX records and the scoreboard
  function automatic logic src_hazard(
    input reg_addr_t                      addr,
    input logic                           valid,
    input logic                           pend,
    input stage_vec_t                     v,
    input reg_addr_t [`HD_DEP_STAGES-1:0] rd,
    input lat_t [`HD_DEP_STAGES-1:0]      lat
  );
    logic hit;
    hit = pend;
    // Stage k result is forwardable once k has caught up with its latency
    for (int k = 0; k < `HD_DEP_STAGES; k++)
      hit = hit | (v[k] & (lat[k] > lat_t'(k)) & (rd[k] == addr));
    return valid & (addr != '0) & hit;
  endfunction

  assign rs1_haz = src_hazard(isd_rs1_i, isd_irs1_v_i, rs1_pend_i,
                              stage_v_i, stage_rd_i, stage_lat_i);
  assign rs2_haz = src_hazard(isd_rs2_i, isd_irs2_v_i, rs2_pend_i,
                              stage_v_i, stage_rd_i, stage_lat_i);

  // Late writer still outstanding to the same destination
  assign waw_haz = isd_iwb_v_i & (isd_rd_i != '0) & rd_pend_i;

  assign data_haz_o = rs1_haz | rs2_haz | waw_haz;

endmodule

/* src/dep_status_pipe.sv */
`timescale 1ns/1ps
`include "hd_cfg.svh"

module dep_status_pipe (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        dispatch_v_i,
  input  logic                                        dispatch_irf_w_i,
  input  hd_reg_pkg::reg_addr_t                       dispatch_rd_i,
  input  hd_pipe_pkg::lat_t                           dispatch_lat_i,
  input  logic                                        dispatch_mem_i,
  output hd_pipe_pkg::stage_vec_t                     stage_v_o,
  output hd_pipe_pkg::stage_vec_t                     stage_mem_o,
  output hd_reg_pkg::reg_addr_t [`HD_DEP_STAGES-1:0]  stage_rd_o,
  output hd_pipe_pkg::lat_t [`HD_DEP_STAGES-1:0]      stage_lat_o
);

  import hd_reg_pkg::*;
  import hd_pipe_pkg::*;

  stage_vec_t                     v_r;
  stage_vec_t                     mem_r;
  lat_t [`HD_DEP_STAGES-1:0]      lat_r;
  reg_addr_t [`HD_DEP_STAGES-1:0] rd_r;

  // Stage 0 takes the dispatched instruction or an empty record
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r   <= '0;
      mem_r <= '0;
      lat_r <= '0;
    end
    else
    begin
      v_r[0]   <= dispatch_v_i;
      mem_r[0] <= dispatch_v_i & dispatch_mem_i;
      // No integer write means nothing to wait for
      lat_r[0] <= (dispatch_v_i && dispatch_irf_w_i) ? dispatch_lat_i : '0;
      for (int k = 1; k < `HD_DEP_STAGES; k++)
      begin
        v_r[k]   <= v_r[k-1];
        mem_r[k] <= mem_r[k-1];
        lat_r[k] <= lat_r[k-1];
      end
    end
  end

  // Destination address travels with its record
  always_ff @(posedge clk_i)
  begin
    rd_r[0] <= dispatch_rd_i;
    for (int k = 1; k < `HD_DEP_STAGES; k++)
      rd_r[k] <= rd_r[k-1];
  end

  assign stage_v_o   = v_r;
  assign stage_mem_o = mem_r;
  assign stage_rd_o  = rd_r;
  assign stage_lat_o = lat_r;

endmodule

/* src/int_scoreboard.sv */
`timescale 1ns/1ps

module int_scoreboard (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  dispatch_v_i,
  input  logic                  dispatch_late_i,
  input  hd_reg_pkg::reg_addr_t dispatch_rd_i,
  input  logic                  commit_miss_i,
  input  logic                  commit_load_i,
  input  hd_reg_pkg::reg_addr_t commit_rd_i,
  input  logic                  clear_v_i,
  input  hd_reg_pkg::reg_addr_t clear_rd_i,
  input  hd_reg_pkg::reg_addr_t rs1_i,
  input  hd_reg_pkg::reg_addr_t rs2_i,
  input  hd_reg_pkg::reg_addr_t rd_i,
  output logic                  rs1_pend_o,
  output logic                  rs2_pend_o,
  output logic                  rd_pend_o
);

  import hd_reg_pkg::*;

  reg_mask_t pend_r;
  reg_mask_t pend_n;
  logic      set_v;
  reg_addr_t set_rd;

  // A missed load re-scores its destination, otherwise the dispatch scores
  assign set_v  = (dispatch_v_i & dispatch_late_i) | (commit_miss_i & commit_load_i);
  assign set_rd = commit_miss_i ? commit_rd_i : dispatch_rd_i;

  always_comb
  begin
    pend_n = pend_r;
    if (clear_v_i)
      pend_n[clear_rd_i] = 1'b0;
    // Set after clear so it wins on a collision; x0 never waits
    if (set_v && (set_rd != '0))
      pend_n[set_rd] = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      pend_r <= '0;
    else
      pend_r <= pend_n;
  end

  assign rs1_pend_o = pend_r[rs1_i];
  assign rs2_pend_o = pend_r[rs2_i];
  assign rd_pend_o  = pend_r[rd_i];

endmodule

/* src/hd_pipe_pkg.sv */
`include "hd_cfg.svh"

package hd_pipe_pkg;

  // EX stages before a result can be forwarded
  // 0 for control and simple integer ops
  // 1 for auxiliary and early memory ops
  // 2 for multiply and final memory ops
  typedef logic [`HD_LAT_W-1:0] lat_t;

  // One flag per tracked EX stage
  typedef logic [`HD_DEP_STAGES-1:0] stage_vec_t;

endpackage

/* src/hd_reg_pkg.sv */
`include "hd_cfg.svh"

package hd_reg_pkg;

  // Architectural register index
  typedef logic [`HD_REG_ADDR_W-1:0] reg_addr_t;

  // One flag per integer register
  typedef logic [`HD_NUM_REGS-1:0] reg_mask_t;

endpackage

/* src/hd_cfg.svh */
`ifndef HD_CFG_SVH
`define HD_CFG_SVH

// Integer register file
`define HD_NUM_REGS 32
`define HD_REG_ADDR_W 5

// Dispatch record depth, one entry each for EX1, EX2 and EX3
`define HD_DEP_STAGES 3

// Latency code width, values 0 to 2
`define HD_LAT_W 2

`endif
